// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ats21Tb -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: alarmBank.sv
module alarmBank #(
  parameter int numClocks = atsPkg::NUM_CLOCKS,
  parameter int numAlarms = atsPkg::NUM_ALARMS
) (
  input  logic                          clk_2x,
  input  logic                          reset,
  atsCmdIf.slave                        cmdA,
  atsCmdIf.slave                        cmdB,
  input  atsPkg::countT [numClocks-1:0] counts,
  input  logic [numClocks-1:0]          ticks,
  output logic [numAlarms-1:0]          data
);
  import atsPkg::*;

  // alarm registers
  logic [numAlarms-1:0] enable;
  logic [numAlarms-1:0] rptFlag;               // rearm after firing
  clockIdxT             asgClk    [numAlarms];  // watched counter
  countT                target    [numAlarms];
  logic [1:0]           pulseLeft [numAlarms];  // cycles of data left

  // decoded writes per alarm
  logic [numAlarms-1:0] wrSet, wrEn, wrFlag;
  clockIdxT             wrClk   [numAlarms];
  countT                wrValue [numAlarms];
  logic [numAlarms-1:0] fire;

  //////////////////////////////////////////////////
  // write decode and match
  //////////////////////////////////////////////////
  always_comb begin
    logic hitA, hitB;
    for (int i = 0; i < numAlarms; i++) begin
      hitA = cmdA.wr && ((cmdA.op == opSetAlarm) || (cmdA.op == opEnAlarm)) &&
             (cmdA.alarmIdx == alarmIdxT'(i));
      hitB = cmdB.wr && ((cmdB.op == opSetAlarm) || (cmdB.op == opEnAlarm)) &&
             (cmdB.alarmIdx == alarmIdxT'(i));
      wrSet[i]   = hitA ? (cmdA.op == opSetAlarm) : (hitB && (cmdB.op == opSetAlarm));
      wrEn[i]    = hitA ? (cmdA.op == opEnAlarm) : (hitB && (cmdB.op == opEnAlarm));
      wrFlag[i]  = hitA ? cmdA.flag : cmdB.flag;  // repeat or enable
      wrClk[i]   = hitA ? cmdA.asgClk : cmdB.asgClk;
      wrValue[i] = hitA ? cmdA.value : cmdB.value;

      // compare on the count before it increments
      // a match during a pulse is ignored so data stays 2 cycles
      fire[i] = enable[i] && (pulseLeft[i] == 2'd0) &&
                ticks[asgClk[i]] && (counts[asgClk[i]] == target[i]);

      data[i] = (pulseLeft[i] != 2'd0);
    end
  end

  //////////////////////////////////////////////////
  // enables and finished pulses
  //////////////////////////////////////////////////
  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numAlarms; i++) begin
        enable[i]    <= 1'b0;
        pulseLeft[i] <= 2'd0;
      end
    end else begin
      for (int i = 0; i < numAlarms; i++) begin
        if (fire[i]) begin
          pulseLeft[i] <= 2'd2;  // data rises here
        end else if (pulseLeft[i] != 2'd0) begin
          pulseLeft[i] <= pulseLeft[i] - 2'd1;
        end

        // writes win over the one-shot disable
        if (wrSet[i]) begin
          enable[i] <= 1'b1;  // armed when set
        end else if (wrEn[i]) begin
          enable[i] <= wrFlag[i];
        end else if (fire[i] && !rptFlag[i]) begin
          enable[i] <= 1'b0;  // one shot done
        end
      end
    end
  end

  // alarm payload
  always_ff @(posedge clk_2x) begin
    for (int i = 0; i < numAlarms; i++) begin
      if (wrSet[i]) begin
        rptFlag[i] <= wrFlag[i];
        asgClk[i]  <= wrClk[i];
        target[i]  <= wrValue[i];
      end
    end
  end

endmodule

// File: ats21Assert.sv
module ats21Assert #(
  parameter int numAlarms = atsPkg::NUM_ALARMS
) (
  input logic                 clk_2x,
  input logic                 reset,
  input logic                 ready,
  input logic [1:0]           stat,
  input logic [numAlarms-1:0] data
);
  timeunit 1ns;
  timeprecision 1ns;

  // ready is a single cycle strobe
  readyOnce: assert property (@(posedge clk_2x) disable iff (reset) ready |=> !ready)
    else $error("ready high two cycles");

  statQuiet: assert property (@(posedge clk_2x) disable iff (reset) !ready |-> stat == 2'b00)
    else $error("stat without ready");

  //////////////////////////////////////////////////
  // two cycle pulses
  //////////////////////////////////////////////////
  for (genvar i = 0; i < numAlarms; i++) begin : pulseChk
    pulseLen: assert property (@(posedge clk_2x) disable iff (reset)
      $rose(data[i]) |=> data[i] ##1 !data[i])
      else $error("data bit %0d pulse not 2 cycles", i);
  end

endmodule

bind ats21Top ats21Assert #(.numAlarms(numAlarms)) chk0 (
  .clk_2x (clk_2x),
  .reset  (reset),
  .ready  (ready),
  .stat   (stat),
  .data   (data)
);

// File: ats21Tb.sv
module ats21Tb;
  timeunit 1ns;
  timeprecision 1ns;
  import atsPkg::*;

  localparam int NC = NUM_CLOCKS;
  localparam int NA = NUM_ALARMS;

  logic clk_2x, reset, req, ready;
  halfT ctrlA, ctrlB;
  logic [1:0] stat;
  logic [NA-1:0] data;
  int errors = 0;
  int tests = 0;
  bit checking = 0;

  // reference model state
  countT mCnt [NC];
  logic mEn [NC];
  rateT mRate [NC];
  logic [1:0] mPh [NC];  // phase since last write
  logic aEn [NA], aRpt [NA];
  clockIdxT aClk [NA];
  countT aTgt [NA];
  int aPulse [NA];
  logic mHave [2], mValid [2];
  halfT mTop [2];
  instrT mInstr [2];
  logic mReady;
  logic [1:0] mStat;
  logic [NA-1:0] mData;

  ats21Top dut0 (.clk_2x(clk_2x), .reset(reset), .req(req), .ctrlA(ctrlA),
    .ctrlB(ctrlB), .ready(ready), .stat(stat), .data(data));

  always #10 clk_2x = ~clk_2x;

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic checkReady(logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR ready got %h exp %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkStat(logic [1:0] got, logic [1:0] exp);
    if (got !== exp) begin
      $display("ERROR stat got %h exp %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkCount(string name, countT got, countT exp);
    if (got !== exp) begin
      $display("ERROR %s got %h exp %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkData(logic [NA-1:0] got, logic [NA-1:0] exp);
    if (got !== exp) begin
      $display("ERROR data got %h exp %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic checkCycles(int got, int exp);
    if (got != exp) begin
      $display("ERROR riseCycle got %h exp %h", got, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // model stepped on every rising edge
  //////////////////////////////////////////////////
  function automatic logic legal(instrT ins);
    logic [2:0] op;
    op = ins[OP_HI:OP_LO];
    if (op == 3'b001) return ins[RATE_HI:RATE_LO] != 2'd3;  // rate 3 rejected
    if (op == 3'b010) return 1'b1;
    if (op == 3'b101 || op == 3'b111) return ins[ALM_HI:ALM_LO] < NA;
    return 1'b0;
  endfunction

  task automatic modelStep();
    logic vNext [2];
    instrT iNext [2];
    halfT h;
    logic [NC-1:0] tk;
    logic [NA-1:0] fr;
    logic [1:0] ack;
    logic [2:0] opA, opB, op;
    logic clash;
    instrT ins;
    for (int c = 0; c < 2; c++) begin
      h = c ? ctrlB : ctrlA;
      vNext[c] = 1'b0;
      iNext[c] = mInstr[c];
      if (mHave[c]) begin
        vNext[c] = req;  // req drop loses the round
        if (req) iNext[c] = {mTop[c], h};
        mHave[c] = 1'b0;
      end else if (req && h[15:13] != 3'b000) begin
        mTop[c] = h;
        mHave[c] = 1'b1;
      end
    end
    // arbitration on the captured pair
    opA = mInstr[0][OP_HI:OP_LO];
    opB = mInstr[1][OP_HI:OP_LO];
    clash = mValid[0] && mValid[1] &&
      (((opA == 3'b001 || opA == 3'b010) && (opB == 3'b001 || opB == 3'b010) &&
        mInstr[0][CLK_HI:CLK_LO] == mInstr[1][CLK_HI:CLK_LO]) ||
       ((opA == 3'b101 || opA == 3'b111) && (opB == 3'b101 || opB == 3'b111) &&
        mInstr[0][ALM_HI:ALM_LO] == mInstr[1][ALM_HI:ALM_LO]));
    for (int c = 0; c < 2; c++) ack[c] = mValid[c] && legal(mInstr[c]) && !clash;
    for (int i = 0; i < NC; i++) begin
      case (mRate[i])
        2'd0: tk[i] = mEn[i];
        2'd1: tk[i] = mEn[i] && mPh[i][0];
        2'd2: tk[i] = mEn[i] && (mPh[i] == 2'd3);
        default: tk[i] = 1'b0;
      endcase
    end
    for (int j = 0; j < NA; j++)
      fr[j] = aEn[j] && (aPulse[j] == 0) && tk[aClk[j]] && (mCnt[aClk[j]] == aTgt[j]);
    for (int i = 0; i < NC; i++) begin
      mPh[i] = mPh[i] + 2'd1;
      if (tk[i]) mCnt[i] = mCnt[i] + 16'd1;
    end
    for (int j = 0; j < NA; j++) begin
      if (fr[j]) aPulse[j] = 2;
      else if (aPulse[j] > 0) aPulse[j]--;
      if (fr[j] && !aRpt[j]) aEn[j] = 1'b0;  // one shot
    end
    // writes override tick and one-shot updates
    for (int c = 0; c < 2; c++) begin
      ins = mInstr[c];
      op = ins[OP_HI:OP_LO];
      if (ack[c]) begin
        case (op)
          3'b001: begin
            mCnt[ins[CLK_HI:CLK_LO]] = ins[VAL_HI:VAL_LO];
            mEn[ins[CLK_HI:CLK_LO]] = 1'b1;
            mRate[ins[CLK_HI:CLK_LO]] = ins[RATE_HI:RATE_LO];
            mPh[ins[CLK_HI:CLK_LO]] = 2'd0;
          end
          3'b010: begin
            mEn[ins[CLK_HI:CLK_LO]] = ins[FLAG_BIT];
            mPh[ins[CLK_HI:CLK_LO]] = 2'd0;
          end
          3'b101: begin
            aEn[ins[ALM_HI:ALM_LO]] = 1'b1;
            aRpt[ins[ALM_HI:ALM_LO]] = ins[FLAG_BIT];
            aClk[ins[ALM_HI:ALM_LO]] = ins[ASG_HI:ASG_LO];
            aTgt[ins[ALM_HI:ALM_LO]] = ins[VAL_HI:VAL_LO];
          end
          default: aEn[ins[ALM_HI:ALM_LO]] = ins[FLAG_BIT];  // enable alarm
        endcase
      end
    end
    mReady = mValid[0] || mValid[1];
    mStat = ack;
    for (int c = 0; c < 2; c++) begin
      mValid[c] = vNext[c];
      mInstr[c] = iNext[c];
    end
    for (int j = 0; j < NA; j++) mData[j] = (aPulse[j] != 0);
  endtask

  task automatic modelReset();
    for (int i = 0; i < NC; i++) begin
      mCnt[i] = '0;
      mEn[i] = 1'b0;
      mRate[i] = 2'd0;
      mPh[i] = 2'd0;
    end
    for (int j = 0; j < NA; j++) begin
      aEn[j] = 1'b0;
      aRpt[j] = 1'b0;
      aClk[j] = '0;
      aTgt[j] = '0;
      aPulse[j] = 0;
    end
    for (int c = 0; c < 2; c++) begin
      mHave[c] = 1'b0;
      mValid[c] = 1'b0;
      mInstr[c] = '0;
    end
    mReady = 1'b0;
    mStat = 2'b00;
    mData = '0;
  endtask

  always @(posedge clk_2x) begin
    if (reset) modelReset();
    else modelStep();
  end

  // per-cycle compare with outputs settled mid period
  always @(negedge clk_2x) begin
    if (checking) begin
      checkReady(ready, mReady);
      checkStat(stat, mStat);
      checkData(data, mData);
      for (int i = 0; i < NC; i++) begin
        checkCount($sformatf("counts[%0d]", i), dut0.counts[i], mCnt[i]);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  function automatic instrT mkClock(logic [2:0] op, clockIdxT c, rateT r, countT v);
    instrT ins;
    ins = '0;
    ins[OP_HI:OP_LO] = op;
    ins[CLK_HI:CLK_LO] = c;
    ins[RATE_HI:RATE_LO] = r;  // bit 23 is the enable on opEnClock
    ins[VAL_HI:VAL_LO] = v;
    return ins;
  endfunction

  function automatic instrT mkAlarm(logic [2:0] op, alarmIdxT a, logic f, clockIdxT c, countT v);
    instrT ins;
    ins = '0;
    ins[OP_HI:OP_LO] = op;
    ins[ALM_HI:ALM_LO] = a;
    ins[FLAG_BIT] = f;
    ins[ASG_HI:ASG_LO] = c;
    ins[VAL_HI:VAL_LO] = v;
    return ins;
  endfunction

  function automatic instrT randInstr();
    instrT ins;
    ins = $urandom;
    ins[VAL_HI:VAL_LO] = countT'($urandom_range(0, 63));  // small values so alarms hit
    return ins;
  endfunction

  // top then bottom half with req left high
  task automatic sendRound(instrT a, instrT b, bit useA, bit useB);
    @(negedge clk_2x);
    req = 1'b1;
    ctrlA = useA ? a[31:16] : '0;
    ctrlB = useB ? b[31:16] : '0;
    @(negedge clk_2x);
    ctrlA = useA ? a[15:0] : '0;
    ctrlB = useB ? b[15:0] : '0;
  endtask

  task automatic idleCycles(int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_2x);
      req = 1'b0;
      ctrlA = '0;
      ctrlB = '0;
    end
  endtask

  task automatic waitRise(int b, int limit, output int n, output bit seen);
    seen = 0;
    for (n = 1; n <= limit; n++) begin
      @(negedge clk_2x);
      req = 1'b0;
      ctrlA = '0;
      ctrlB = '0;
      if (data[b]) begin
        seen = 1;
        break;
      end
    end
  endtask

  task automatic endTest(string name, int errBefore);
    tests++;
    $display("test %s: %0d errors", name, errors - errBefore);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  initial begin
    int e, n, k, per;
    bit seen;
    countT v;
    rateT r;
    instrT a, b;
    void'($urandom(32'ha255));
    clk_2x = 1'b0;
    reset = 1'b1;
    req = 1'b0;
    ctrlA = '0;
    ctrlB = '0;
    repeat (4) @(posedge clk_2x);
    @(negedge clk_2x);
    reset = 1'b0;
    checking = 1;

    e = errors;  // reset quiet
    for (int i = 0; i < 50; i++) begin
      @(negedge clk_2x);
      checkStat(stat, 2'b00);
      checkData(data, '0);
    end
    endTest("reset", e);

    e = errors;  // exact rise cycle per rate
    for (int i = 0; i < 4; i++) begin
      v = countT'($urandom);
      r = rateT'($urandom_range(0, 2));
      k = $urandom_range(1, 20);
      per = (r == 2'd0) ? 1 : (r == 2'd1) ? 2 : 4;
      sendRound(mkClock(3'b001, clockIdxT'(i), r, v),
                mkAlarm(3'b101, alarmIdxT'(i), 1'b0, clockIdxT'(i), v + countT'(k)), 1, 1);
      waitRise(i, 200, n, seen);
      if (!seen) begin
        $display("alarm %0d never fired on its counter", i);
        errors++;
      end else checkCycles(n, 2 + (k + 1) * per);
      idleCycles(4);
    end
    endTest("counter rates", e);

    e = errors;  // one shot and repeat over a full wrap
    v = countT'($urandom);
    sendRound(mkClock(3'b001, 4'd4, 2'd0, v),
              mkAlarm(3'b101, 5'd4, 1'b0, 4'd4, v + 16'd2), 1, 1);
    waitRise(4, 20, n, seen);
    if (!seen) begin
      $display("one-shot alarm did not fire");
      errors++;
    end
    idleCycles(3);
    waitRise(4, 65600, n, seen);
    if (seen) begin
      $display("one-shot alarm fired again after the counter wrapped");
      errors++;
    end
    sendRound(mkClock(3'b001, 4'd5, 2'd0, v),
              mkAlarm(3'b101, 5'd5, 1'b1, 4'd5, v + 16'd2), 1, 1);
    waitRise(5, 20, n, seen);
    if (!seen) begin
      $display("repeat alarm did not fire on its first match");
      errors++;
    end
    idleCycles(3);
    waitRise(5, 65600, n, seen);
    if (!seen) begin
      $display("repeat alarm did not fire after the counter wrapped");
      errors++;
    end
    endTest("repeat", e);

    e = errors;  // enable and disable
    sendRound(mkClock(3'b001, 4'd6, 2'd0, 16'd0), mkAlarm(3'b101, 5'd6, 1'b0, 4'd6, 16'd30), 1, 1);
    sendRound(mkClock(3'b010, 4'd6, 2'b00, 16'd0), '0, 1, 0);
    waitRise(6, 60, n, seen);
    if (seen) begin
      $display("alarm fired while its counter was stopped");
      errors++;
    end
    sendRound(mkAlarm(3'b111, 5'd6, 1'b0, 4'd0, 16'd0), mkClock(3'b010, 4'd6, 2'b10, 16'd0), 1, 1);
    waitRise(6, 60, n, seen);
    if (seen) begin
      $display("disabled alarm still fired");
      errors++;
    end
    sendRound(mkAlarm(3'b111, 5'd6, 1'b1, 4'd0, 16'd0), mkClock(3'b001, 4'd6, 2'd0, 16'd0), 1, 1);
    waitRise(6, 100, n, seen);
    if (!seen) begin
      $display("re-enabled alarm did not fire");
      errors++;
    end else checkCycles(n, 2 + (30 + 1) * 1);  // target 30 after a load of 0 at rate 0
    idleCycles(3);
    endTest("enable", e);

    e = errors;  // ack and nack with forced conflicts now and then
    for (int i = 0; i < 200; i++) begin
      a = randInstr();
      b = randInstr();
      if ($urandom_range(0, 2) == 0) b[31:24] = a[31:24];
      sendRound(a, b, $urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0);
      idleCycles(1);
    end
    idleCycles(3);
    endTest("ack rules", e);

    e = errors;  // back to back mixed rounds
    for (int i = 0; i < 1000; i++) begin
      sendRound(randInstr(), randInstr(), $urandom_range(0, 1), $urandom_range(0, 1));
    end
    idleCycles(10);
    endTest("mixed traffic", e);

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: ats21Top.sv
module ats21Top #(
  parameter int numClocks = atsPkg::NUM_CLOCKS,
  parameter int numAlarms = atsPkg::NUM_ALARMS
) (
  input  logic                 clk_2x,
  input  logic                 reset,
  input  logic                 req,    // shared by both clients
  input  atsPkg::halfT         ctrlA,
  input  atsPkg::halfT         ctrlB,
  output logic                 ready,
  output logic [1:0]           stat,   // bit 0 client A
  output logic [numAlarms-1:0] data    // one bit per alarm
);
  import atsPkg::*;

  instrT                instrA, instrB;
  logic                 validA, validB;
  countT [numClocks-1:0] counts;
  logic [numClocks-1:0] ticks;

  // per-client command buses
  atsCmdIf cmdA ();
  atsCmdIf cmdB ();

  //////////////////////////////////////////////////
  // instruction capture
  //////////////////////////////////////////////////
  instrCapture capA (
    .clk_2x (clk_2x),
    .reset  (reset),
    .req    (req),
    .half   (ctrlA),
    .instr  (instrA),
    .valid  (validA)
  );

  instrCapture capB (
    .clk_2x (clk_2x),
    .reset  (reset),
    .req    (req),
    .half   (ctrlB),
    .instr  (instrB),
    .valid  (validB)
  );

  // decode and ack
  cmdArbiter arb0 (
    .clk_2x (clk_2x),
    .reset  (reset),
    .instrA (instrA),
    .validA (validA),
    .instrB (instrB),
    .validB (validB),
    .ready  (ready),
    .stat   (stat),
    .cmdA   (cmdA.master),
    .cmdB   (cmdB.master)
  );

  //////////////////////////////////////////////////
  // banks
  //////////////////////////////////////////////////
  counterBank #(
    .numClocks (numClocks)
  ) cnt0 (
    .clk_2x (clk_2x),
    .reset  (reset),
    .cmdA   (cmdA.slave),
    .cmdB   (cmdB.slave),
    .counts (counts),
    .ticks  (ticks)
  );

  alarmBank #(
    .numClocks (numClocks),
    .numAlarms (numAlarms)
  ) alm0 (
    .clk_2x (clk_2x),
    .reset  (reset),
    .cmdA   (cmdA.slave),
    .cmdB   (cmdB.slave),
    .counts (counts),
    .ticks  (ticks),
    .data   (data)
  );

endmodule

// File: atsCmdIf.sv
// one decoded command per client, arbiter to both banks
interface atsCmdIf;
  import atsPkg::*;

  logic     wr;        // acked write strobe
  opcodeT   op;        // opNop when not acked
  clockIdxT clockIdx;  // target counter
  alarmIdxT alarmIdx;  // target alarm
  rateT     rate;      // set counter only
  logic     flag;      // enable or repeat bit
  clockIdxT asgClk;    // counter watched by alarm
  countT    value;     // load value or target

  // arbiter side
  modport master (
    output wr, op, clockIdx, alarmIdx,
    output rate, flag, asgClk, value
  );

  // bank side
  modport slave (
    input wr, op, clockIdx, alarmIdx,
    input rate, flag, asgClk, value
  );

endinterface

// File: atsPkg.sv
package atsPkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////
  localparam int NUM_CLOCKS = 16;  // default counter count
  localparam int NUM_ALARMS = 24;  // default alarm count
  localparam int COUNT_W    = 16;  // counter width
  localparam int HALF_W     = 16;  // one transfer on ctrlA/ctrlB

  // vector types
  typedef logic [COUNT_W-1:0]  countT;     // count or alarm target
  typedef logic [3:0]          clockIdxT;  // counter select
  typedef logic [4:0]          alarmIdxT;  // alarm select
  typedef logic [1:0]          rateT;      // prescaler rate code
  typedef logic [HALF_W-1:0]   halfT;      // one instruction half
  typedef logic [2*HALF_W-1:0] instrT;     // full instruction

  // rate codes
  localparam rateT RATE_ALL     = 2'd0;  // every cycle
  localparam rateT RATE_HALF    = 2'd1;  // every 2nd cycle
  localparam rateT RATE_QUARTER = 2'd2;  // every 4th cycle
  localparam rateT RATE_BAD     = 2'd3;  // rejected on set counter

  // opcodes, anything else is nacked
  typedef enum logic [2:0] {
    opNop      = 3'b000,
    opSetClock = 3'b001,
    opEnClock  = 3'b010,
    opSetAlarm = 3'b101,
    opEnAlarm  = 3'b111
  } opcodeT;

  //////////////////////////////////////////////////
  // instruction field positions
  //////////////////////////////////////////////////
  localparam int OP_HI   = 31;
  localparam int OP_LO   = 29;
  localparam int CLK_HI  = 28;  // counter index
  localparam int CLK_LO  = 25;
  localparam int ALM_HI  = 28;  // alarm index
  localparam int ALM_LO  = 24;
  localparam int RATE_HI = 23;
  localparam int RATE_LO = 22;
  localparam int FLAG_BIT = 23; // enable or repeat
  localparam int ASG_HI  = 19;  // counter an alarm watches
  localparam int ASG_LO  = 16;
  localparam int VAL_HI  = 15;
  localparam int VAL_LO  = 0;

endpackage

// File: cmdArbiter.sv
module cmdArbiter (
  input  logic          clk_2x,
  input  logic          reset,
  input  atsPkg::instrT instrA,
  input  logic          validA,
  input  atsPkg::instrT instrB,
  input  logic          validB,
  output logic          ready,
  output logic [1:0]    stat,
  atsCmdIf.master       cmdA,
  atsCmdIf.master       cmdB
);
  import atsPkg::*;

  opcodeT opA, opB;
  logic   cntA, cntB;  // counter class
  logic   almA, almB;  // alarm class
  logic   conflict;
  logic   ackA, ackB;

  //////////////////////////////////////////////////
  // decode helpers
  //////////////////////////////////////////////////
  function automatic opcodeT opOf(instrT ins);
    return opcodeT'(ins[OP_HI:OP_LO]);
  endfunction

  function automatic logic isCnt(opcodeT op);
    return (op == opSetClock) || (op == opEnClock);
  endfunction

  function automatic logic isAlm(opcodeT op);
    return (op == opSetAlarm) || (op == opEnAlarm);
  endfunction

  // legal opcode with legal fields
  function automatic logic fieldsOk(instrT ins);
    opcodeT op;
    op = opOf(ins);
    if (isCnt(op)) begin
      return !((op == opSetClock) && (rateT'(ins[RATE_HI:RATE_LO]) == RATE_BAD));
    end
    if (isAlm(op)) begin
      return alarmIdxT'(ins[ALM_HI:ALM_LO]) < NUM_ALARMS;  // 24 and up rejected
    end
    return 1'b0;  // 000, 011, 100, 110
  endfunction

  assign opA  = opOf(instrA);
  assign opB  = opOf(instrB);
  assign cntA = isCnt(opA);
  assign cntB = isCnt(opB);
  assign almA = isAlm(opA);
  assign almB = isAlm(opB);

  // same class and same index nacks both sides
  assign conflict = validA && validB &&
                    ((cntA && cntB && (instrA[CLK_HI:CLK_LO] == instrB[CLK_HI:CLK_LO])) ||
                     (almA && almB && (instrA[ALM_HI:ALM_LO] == instrB[ALM_HI:ALM_LO])));

  assign ackA = validA && fieldsOk(instrA) && !conflict;
  assign ackB = validB && fieldsOk(instrB) && !conflict;

  //////////////////////////////////////////////////
  // command buses, applied by the banks at N+2
  //////////////////////////////////////////////////
  assign cmdA.wr       = ackA;
  assign cmdA.op       = ackA ? opA : opNop;
  assign cmdA.clockIdx = instrA[CLK_HI:CLK_LO];
  assign cmdA.alarmIdx = instrA[ALM_HI:ALM_LO];
  assign cmdA.rate     = instrA[RATE_HI:RATE_LO];
  assign cmdA.flag     = instrA[FLAG_BIT];
  assign cmdA.asgClk   = instrA[ASG_HI:ASG_LO];
  assign cmdA.value    = instrA[VAL_HI:VAL_LO];

  assign cmdB.wr       = ackB;
  assign cmdB.op       = ackB ? opB : opNop;
  assign cmdB.clockIdx = instrB[CLK_HI:CLK_LO];
  assign cmdB.alarmIdx = instrB[ALM_HI:ALM_LO];
  assign cmdB.rate     = instrB[RATE_HI:RATE_LO];
  assign cmdB.flag     = instrB[FLAG_BIT];
  assign cmdB.asgClk   = instrB[ASG_HI:ASG_LO];
  assign cmdB.value    = instrB[VAL_HI:VAL_LO];

  // status out, same edge as the writes
  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      ready <= 1'b0;
      stat  <= 2'b00;
    end else begin
      ready <= validA || validB;  // idle client still gets ack 0
      stat  <= {ackB, ackA};
    end
  end

endmodule

// File: counterBank.sv
module counterBank #(
  parameter int numClocks = atsPkg::NUM_CLOCKS
) (
  input  logic                          clk_2x,
  input  logic                          reset,
  atsCmdIf.slave                        cmdA,
  atsCmdIf.slave                        cmdB,
  output atsPkg::countT [numClocks-1:0] counts,
  output logic [numClocks-1:0]          ticks
);
  import atsPkg::*;

  logic [1:0]           prescale;             // free running
  logic [numClocks-1:0] enable;
  rateT                 rate     [numClocks];
  logic [1:0]           phaseOfs [numClocks]; // prescale value at last write
  logic [numClocks-1:0] wrSet, wrEn, wrFlag;
  rateT                 wrRate   [numClocks];
  countT                wrValue  [numClocks];

  //////////////////////////////////////////////////
  // write decode and tick forming
  //////////////////////////////////////////////////
  always_comb begin
    logic       hitA, hitB;
    logic [1:0] ph;
    for (int i = 0; i < numClocks; i++) begin
      hitA = cmdA.wr && ((cmdA.op == opSetClock) || (cmdA.op == opEnClock)) &&
             (cmdA.clockIdx == clockIdxT'(i));
      hitB = cmdB.wr && ((cmdB.op == opSetClock) || (cmdB.op == opEnClock)) &&
             (cmdB.clockIdx == clockIdxT'(i));
      // indices never collide, A wins otherwise
      wrSet[i]   = hitA ? (cmdA.op == opSetClock) : (hitB && (cmdB.op == opSetClock));
      wrEn[i]    = hitA ? (cmdA.op == opEnClock) : (hitB && (cmdB.op == opEnClock));
      wrFlag[i]  = hitA ? cmdA.flag : cmdB.flag;
      wrRate[i]  = hitA ? cmdA.rate : cmdB.rate;
      wrValue[i] = hitA ? cmdA.value : cmdB.value;

      ph = prescale - phaseOfs[i];  // 0 in the cycle after a write
      case (rate[i])
        RATE_ALL:     ticks[i] = enable[i];
        RATE_HALF:    ticks[i] = enable[i] && ph[0];
        RATE_QUARTER: ticks[i] = enable[i] && (&ph);
        default:      ticks[i] = 1'b0;  // never loaded
      endcase
    end
  end

  //////////////////////////////////////////////////
  // counter state
  //////////////////////////////////////////////////
  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      prescale <= 2'd0;
      for (int i = 0; i < numClocks; i++) begin
        enable[i]   <= 1'b0;
        rate[i]     <= RATE_ALL;
        phaseOfs[i] <= 2'd0;
        counts[i]   <= '0;
      end
    end else begin
      prescale <= prescale + 2'd1;
      for (int i = 0; i < numClocks; i++) begin
        if (wrSet[i]) begin
          enable[i]   <= 1'b1;            // set also enables
          rate[i]     <= wrRate[i];
          counts[i]   <= wrValue[i];      // load beats increment
          phaseOfs[i] <= prescale + 2'd1; // restart rate phase
        end else begin
          if (wrEn[i]) begin
            enable[i]   <= wrFlag[i];
            phaseOfs[i] <= prescale + 2'd1;
          end
          if (ticks[i]) begin
            counts[i] <= counts[i] + 1'b1;  // wraps at 16 bits
          end
        end
      end
    end
  end

endmodule

// File: instrCapture.sv
module instrCapture (
  input  logic          clk_2x,
  input  logic          reset,
  input  logic          req,
  input  atsPkg::halfT  half,
  output atsPkg::instrT instr,
  output logic          valid
);
  import atsPkg::*;

  typedef enum logic {
    idle,
    haveTop
  } capStateT;

  capStateT state;
  halfT     topHalf;  // first transfer of the round
  logic     startOk;

  // a round opens with req and a nonzero opcode in the top half
  assign startOk = req && (half[OP_HI-HALF_W:OP_LO-HALF_W] != '0);

  //////////////////////////////////////////////////
  // two word FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk_2x or posedge reset) begin
    if (reset) begin
      state <= idle;
      valid <= 1'b0;
    end else begin
      valid <= 1'b0;  // one cycle strobe
      case (state)
        idle: begin
          if (startOk) begin
            state <= haveTop;
          end
        end
        haveTop: begin
          // req dropped means the top half is thrown away
          valid <= req;
          state <= idle;  // next top half may follow at once
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // payload path
  always_ff @(posedge clk_2x) begin
    if ((state == idle) && startOk) begin
      topHalf <= half;  // hold top
    end
    if ((state == haveTop) && req) begin
      instr <= {topHalf, half};  // join with bottom
    end
  end

endmodule

// File: sim.f
atsPkg.sv
atsCmdIf.sv
instrCapture.sv
cmdArbiter.sv
counterBank.sv
alarmBank.sv
ats21Top.sv
ats21Assert.sv
ats21Tb.sv
